// ==== acore_const_pkg.sv ====
package acore_const_pkg;

    // interleaving
    localparam int Nti = 4;                  // number of time-interleaved slices
    localparam int Nidx = 2;                 // bits to address one slice

    // data path widths
    localparam int Nin = 8;                  // signed sample from the pad model
    localparam int Nadc = 8;                 // magnitude code out of a slice

    // largest code a slice can return
    localparam int CODE_MAX = 2**Nadc - 1;

    // configuration widths
    localparam int Ntrim = 4;                // v2t offset trim per slice
    localparam int Ndiv = 3;                 // input divider setting

endpackage

// ==== acore_type_pkg.sv ====
package acore_type_pkg;
    import acore_const_pkg::*;

    // sample as seen at the pad, two's complement
    typedef logic signed [Nin-1:0] sample_t;

    typedef logic [Nadc-1:0] code_t;         // unsigned magnitude
    typedef logic [Ntrim-1:0] trim_t;

    // one trim per slice, slice 0 in the low bits
    typedef trim_t [Nti-1:0] trim_arr_t;

    // conversion sequence of a single slice
    typedef enum logic [1:0] {
        SLICE_IDLE,                          // waiting for a load
        SLICE_CONVERT,                       // counting up to the target
        SLICE_HOLD                           // result presented until taken
    } slice_state_e;

endpackage

// ==== slice_intf.sv ====
interface slice_intf import acore_type_pkg::*; ();

    // sample path from the sample-and-hold
    sample_t sample;
    logic load;                              // one-cycle load strobe

    // static configuration from the top ports
    logic en_slice;
    trim_t ctl_v2t_p;
    trim_t ctl_v2t_n;

    // conversion result
    code_t adder_out;
    logic sign_out;
    logic valid;                             // level, held until taken
    logic busy;

    logic taken;                             // retimer has consumed the result

    modport snh (
        output sample, load,
        input busy
    );

    modport slice (
        input sample, load, en_slice, ctl_v2t_p, ctl_v2t_n, taken,
        output adder_out, sign_out, valid, busy
    );

    modport retimer (
        input adder_out, sign_out, valid,
        output taken
    );

endinterface

// ==== input_divider.sv ====
module input_divider import acore_const_pkg::*; (
    input wire logic ext_clk_i,
    input wire logic rst_n_i,
    input wire logic [Ndiv-1:0] ndiv_i,      // tick period is ndiv_i+1 cycles
    input wire logic bypass_div_i,           // tick on every cycle
    output logic sample_tick_o
);

    logic [Ndiv-1:0] cnt_q;
    logic tick_q;

    // down-counter, reload with the setting on zero
    always_ff @(posedge ext_clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= ndiv_i;                 // first tick ndiv_i+1 cycles out
            tick_q <= 1'b0;
        end else begin
            if (cnt_q == '0) begin
                cnt_q <= ndiv_i;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end

            if (bypass_div_i) begin
                tick_q <= 1'b1;
            end else begin
                tick_q <= (cnt_q == '0);
            end
        end
    end

    assign sample_tick_o = tick_q;

endmodule

// ==== snh.sv ====
module snh import acore_const_pkg::*, acore_type_pkg::*; (
    input wire logic ext_clk_i,
    input wire logic rst_n_i,
    input wire logic sample_tick_i,
    input sample_t rx_code_i,
    slice_intf.snh slice_io [Nti-1:0],
    output logic overrun_o                   // sticky until reset
);

    sample_t sample_q;
    logic [Nti-1:0] load_q;
    logic [Nti-1:0] busy;
    logic [Nidx-1:0] tok_q;                  // slice that owns the next sample
    logic overrun_q;

    // fan the held sample out, collect busy back
    generate
        for (genvar k = 0; k < Nti; k++) begin : g_slice
            assign slice_io[k].sample = sample_q;
            assign slice_io[k].load = load_q[k];
            assign busy[k] = slice_io[k].busy;
        end
    endgenerate

    // hold capacitor
    always_ff @(posedge ext_clk_i) begin
        if (sample_tick_i) begin
            sample_q <= rx_code_i;
        end
    end

    always_ff @(posedge ext_clk_i) begin
        if (!rst_n_i) begin
            load_q <= '0;
            tok_q <= '0;
            overrun_q <= 1'b0;
        end else begin
            load_q <= '0;
            if (sample_tick_i) begin
                if (!busy[tok_q]) begin
                    load_q[tok_q] <= 1'b1;
                    // pass the token on, like en_sync down the chain
                    if (tok_q == Nidx'(Nti-1)) begin
                        tok_q <= '0;
                    end else begin
                        tok_q <= tok_q + 1'b1;
                    end
                end else begin
                    overrun_q <= 1'b1;       // sample lost, token stays
                end
            end
        end
    end

    assign overrun_o = overrun_q;

endmodule

// ==== stochastic_adc_slice.sv ====
module stochastic_adc_slice import acore_const_pkg::*, acore_type_pkg::*; (
    input wire logic ext_clk_i,
    input wire logic rst_n_i,
    slice_intf.slice slice_io
);

    slice_state_e state_q;

    logic neg;
    logic signed [Nin:0] s_ext;
    logic [Nin:0] mag;                       // |sample|, room for -min
    trim_t trim;
    logic [Nin+1:0] sum;
    code_t target;

    code_t target_q;
    code_t cnt_q;
    code_t res_q;
    logic sign_q;

    // front end: sign detect and trimmed magnitude
    assign neg = slice_io.sample[Nin-1];
    assign s_ext = slice_io.sample;          // sign extend
    assign mag = s_ext[Nin] ? -s_ext : s_ext;
    assign trim = neg ? slice_io.ctl_v2t_n : slice_io.ctl_v2t_p;
    assign sum = (Nin+2)'(mag) + (Nin+2)'(trim);
    assign target = (sum > CODE_MAX) ? Nadc'(CODE_MAX) : sum[Nadc-1:0];

    always_ff @(posedge ext_clk_i) begin
        if (!rst_n_i) begin
            state_q <= SLICE_IDLE;
        end else begin
            case (state_q)
                SLICE_IDLE: begin
                    if (slice_io.load) begin
                        // nothing to count when off or at zero
                        if (!slice_io.en_slice || target == '0) begin
                            state_q <= SLICE_HOLD;
                        end else begin
                            state_q <= SLICE_CONVERT;
                        end
                    end
                end
                SLICE_CONVERT: begin
                    if (cnt_q == target_q) begin
                        state_q <= SLICE_HOLD;
                    end
                end
                SLICE_HOLD: begin
                    if (slice_io.taken) begin
                        state_q <= SLICE_IDLE;
                    end
                end
                default: state_q <= SLICE_IDLE;
            endcase
        end
    end

    // v2t counter and held result
    always_ff @(posedge ext_clk_i) begin
        case (state_q)
            SLICE_IDLE: begin
                if (slice_io.load) begin
                    target_q <= target;
                    cnt_q <= Nadc'(1);
                    sign_q <= slice_io.en_slice & ~neg;   // 1 for non-negative
                    res_q <= '0;
                end
            end
            SLICE_CONVERT: begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == target_q) begin
                    res_q <= cnt_q;
                end
            end
            default: ;
        endcase
    end

    assign slice_io.adder_out = res_q;
    assign slice_io.sign_out = sign_q;
    assign slice_io.valid = (state_q == SLICE_HOLD);
    assign slice_io.busy = (state_q != SLICE_IDLE);

endmodule

// ==== adc_retimer.sv ====
module adc_retimer import acore_const_pkg::*, acore_type_pkg::*; (
    input wire logic ext_clk_i,
    input wire logic rst_n_i,
    slice_intf.retimer slice_io [Nti-1:0],
    output code_t adder_out_o,
    output logic sign_out_o,
    output logic [Nidx-1:0] slice_idx_o,
    output logic adc_valid_o,
    output logic frame_o                     // plays the part of clk_adc
);

    code_t [Nti-1:0] code_v;
    logic [Nti-1:0] sign_v;
    logic [Nti-1:0] valid_v;
    logic [Nti-1:0] taken_q;
    logic [Nidx-1:0] ptr_q;                  // read pointer in sample order
    logic last;
    logic take;

    generate
        for (genvar k = 0; k < Nti; k++) begin : g_slice
            assign code_v[k] = slice_io[k].adder_out;
            assign sign_v[k] = slice_io[k].sign_out;
            assign valid_v[k] = slice_io[k].valid;
            assign slice_io[k].taken = taken_q[k];
        end
    endgenerate

    assign last = (ptr_q == Nidx'(Nti-1));
    assign take = valid_v[ptr_q];            // only the slice at the pointer counts

    always_ff @(posedge ext_clk_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
            taken_q <= '0;
            adc_valid_o <= 1'b0;
            frame_o <= 1'b0;
        end else begin
            taken_q <= '0;
            adc_valid_o <= take;
            frame_o <= take & last;
            if (take) begin
                taken_q[ptr_q] <= 1'b1;
                ptr_q <= last ? '0 : ptr_q + 1'b1;
            end
        end
    end

    // output word
    always_ff @(posedge ext_clk_i) begin
        if (take) begin
            adder_out_o <= code_v[ptr_q];
            sign_out_o <= sign_v[ptr_q];
            slice_idx_o <= ptr_q;
        end
    end

endmodule

// ==== analog_core.sv ====
module analog_core import acore_const_pkg::*, acore_type_pkg::*; (
    input wire logic ext_clk_i,              // drives every register
    input wire logic rst_n_i,

    input sample_t rx_code_i,                // quantized pad voltage

    // input divider control
    input wire logic [Ndiv-1:0] ndiv_i,
    input wire logic bypass_div_i,

    // per-slice configuration
    input wire logic [Nti-1:0] en_slice_i,
    input trim_arr_t ctl_v2t_p_i,
    input trim_arr_t ctl_v2t_n_i,

    // retimed adc output
    output code_t adder_out_o,
    output logic sign_out_o,
    output logic [Nidx-1:0] slice_idx_o,
    output logic adc_valid_o,
    output logic frame_o,                    // last slice of a round
    output logic overrun_o
);

    logic sample_tick;

    slice_intf slice_if [Nti-1:0] ();

    // sampling tick from the external clock
    input_divider i_indiv (
        .ext_clk_i(ext_clk_i),
        .rst_n_i(rst_n_i),
        .ndiv_i(ndiv_i),
        .bypass_div_i(bypass_div_i),
        .sample_tick_o(sample_tick)
    );

    // first-level sample-and-hold
    snh i_snh (
        .ext_clk_i(ext_clk_i),
        .rst_n_i(rst_n_i),
        .sample_tick_i(sample_tick),
        .rx_code_i(rx_code_i),
        .slice_io(slice_if),
        .overrun_o(overrun_o)
    );

    // time-interleaved slices
    generate
        for (genvar k = 0; k < Nti; k++) begin : g_adc
            assign slice_if[k].en_slice = en_slice_i[k];
            assign slice_if[k].ctl_v2t_p = ctl_v2t_p_i[k];
            assign slice_if[k].ctl_v2t_n = ctl_v2t_n_i[k];

            stochastic_adc_slice i_adc (
                .ext_clk_i(ext_clk_i),
                .rst_n_i(rst_n_i),
                .slice_io(slice_if[k])
            );
        end
    endgenerate

    // back into sample order
    adc_retimer i_retimer (
        .ext_clk_i(ext_clk_i),
        .rst_n_i(rst_n_i),
        .slice_io(slice_if),
        .adder_out_o(adder_out_o),
        .sign_out_o(sign_out_o),
        .slice_idx_o(slice_idx_o),
        .adc_valid_o(adc_valid_o),
        .frame_o(frame_o)
    );

endmodule

// ==== tb_analog_core.sv ====
module tb_analog_core import acore_const_pkg::*, acore_type_pkg::*; ();

    // output count of every test times the worst cycles one sample can take
    localparam int TOTAL_OUT = 4 + 48 + 40 + 40 + 64 + 32;
    localparam int CYCLE_LIMIT = TOTAL_OUT * (8 + 256);

    localparam trim_arr_t TRIM_P = 16'h2f95; // slice 0 in the low nibble
    localparam trim_arr_t TRIM_N = 16'h7a3c;

    logic ext_clk;
    logic rst_n;
    sample_t rx_code;
    logic [Ndiv-1:0] ndiv;
    logic bypass_div;
    logic [Nti-1:0] en_slice;
    trim_arr_t v2t_p;
    trim_arr_t v2t_n;
    code_t adder_out;
    logic sign_out;
    logic [Nidx-1:0] slice_idx;
    logic adc_valid;
    logic frame;
    logic overrun;

    logic [31:0] lfsr;
    sample_t ref_q[$];                       // every value driven on rx_code
    logic [Nidx-1:0] exp_idx;                // running round-robin count
    int out_cnt;
    int frame_cnt;
    int err_cnt;
    int cycle_cnt;
    logic seen_max;
    logic seen_min;
    logic quiet_ovr;
    logic in_rst_q;                          // DUT saw reset on the last edge
    logic post_rst_q;

    analog_core UUT (
        .ext_clk_i(ext_clk),
        .rst_n_i(rst_n),
        .rx_code_i(rx_code),
        .ndiv_i(ndiv),
        .bypass_div_i(bypass_div),
        .en_slice_i(en_slice),
        .ctl_v2t_p_i(v2t_p),
        .ctl_v2t_n_i(v2t_n),
        .adder_out_o(adder_out),
        .sign_out_o(sign_out),
        .slice_idx_o(slice_idx),
        .adc_valid_o(adc_valid),
        .frame_o(frame),
        .overrun_o(overrun)
    );

    initial begin
        ext_clk = 1'b0;
        forever #4 ext_clk = ~ext_clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_sample(input int width, output sample_t s);
        logic [7:0] raw;
        raw = '0;
        for (int b = 0; b < width; b++) begin
            lfsr = lfsr_next(lfsr);
            raw[b] = lfsr[0];
        end
        for (int b = width; b < 8; b++) begin
            raw[b] = raw[width-1];           // sign extend narrow draws
        end
        s = sample_t'(raw);
    endtask

    // {sign, code} a slice should return for one sample
    function automatic logic [Nadc:0] expect_result(input sample_t s, input int idx);
        int mag;
        int trim;
        if (!en_slice[idx]) begin
            return '0;
        end
        mag = (s < 0) ? -int'(s) : int'(s);
        trim = (s < 0) ? int'(v2t_n[idx]) : int'(v2t_p[idx]);
        mag = mag + trim;
        if (mag > 255) begin
            mag = 255;
        end
        return {s >= 0, mag[7:0]};
    endfunction

    task automatic report_mismatch(input string msg);
        err_cnt++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    task automatic report_fault(input string msg);
        err_cnt++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic check_output();
        logic [Nadc:0] got;
        sample_t s;
        logic hit;
        got = {sign_out, adder_out};
        hit = 1'b0;
        assert (slice_idx == exp_idx)
            else report_mismatch($sformatf("slice index %0d, expected %0d", slice_idx, exp_idx));
        // oldest fitting sample, the ones behind it stay for later outputs
        while (!hit && ref_q.size() > 0) begin
            s = ref_q.pop_front();
            if (slice_idx == exp_idx && expect_result(s, int'(exp_idx)) == got) begin
                hit = 1'b1;
                if (s == sample_t'(8'h7f)) seen_max = 1'b1;
                if (s == sample_t'(8'h80)) seen_min = 1'b1;
            end
        end
        assert (hit)
            else report_mismatch($sformatf("slice %0d code %0d sign %0b fits no queued sample",
                                           slice_idx, adder_out, sign_out));
        if (frame) frame_cnt++;
        exp_idx = exp_idx + 1'b1;
        out_cnt++;
    endtask

    always @(negedge ext_clk) begin
        if (rst_n && adc_valid) begin
            check_output();
        end
    end

    always @(posedge ext_clk) begin
        in_rst_q <= !rst_n;
        post_rst_q <= in_rst_q;
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    assert property (@(negedge ext_clk)
        (in_rst_q || post_rst_q) |-> !adc_valid && !frame && !overrun)
        else report_fault("output active during reset or in the cycle after it");
    assert property (@(negedge ext_clk) disable iff (!rst_n)
        frame == (adc_valid && slice_idx == Nidx'(Nti-1)))
        else report_mismatch("frame marker out of line with the last slice");
    assert property (@(negedge ext_clk) disable iff (!rst_n) quiet_ovr |-> !overrun)
        else report_fault("overrun raised while sampling slowly");

    // reconfigure while the DUT sits in reset
    task automatic apply_reset(input logic [Ndiv-1:0] div, input logic byp,
                               input logic [Nti-1:0] en, input trim_arr_t tp, input trim_arr_t tn);
        @(posedge ext_clk);
        rst_n <= 1'b0;
        ndiv <= div;
        bypass_div <= byp;
        en_slice <= en;
        v2t_p <= tp;
        v2t_n <= tn;
        repeat (2) @(posedge ext_clk);
        ref_q.delete();
        exp_idx = '0;
        out_cnt = 0;
        frame_cnt = 0;
        seen_max = 1'b0;
        seen_min = 1'b0;
        rst_n <= 1'b1;
    endtask

    task automatic drive_until(input int n_out, input int width, input logic extremes);
        sample_t s;
        int cyc;
        cyc = 0;
        while (out_cnt < n_out) begin
            @(posedge ext_clk);
            if (extremes && cyc < 64) begin
                s = cyc[3] ? sample_t'(8'h7f) : sample_t'(8'h80);   // one tick per hold
            end else begin
                draw_sample(width, s);
            end
            rx_code <= s;
            ref_q.push_back(s);
            cyc++;
        end
    endtask

    task automatic close_test(input int num, input string name, input int err0);
        $display("test %0d %s: %0d outputs, %0d errors", num, name, out_cnt, err_cnt - err0);
    endtask

    initial begin
        int err0;
        lfsr = 32'h7da28561;
        rst_n = 1'b0;
        rx_code = '0;
        ndiv = 3'd7;
        bypass_div = 1'b0;
        en_slice = '1;
        v2t_p = '0;
        v2t_n = '0;
        err_cnt = 0;
        cycle_cnt = 0;
        quiet_ovr = 1'b0;
        in_rst_q = 1'b0;
        post_rst_q = 1'b0;

        err0 = err_cnt;
        apply_reset(3'd7, 1'b0, 4'hf, '0, '0);
        drive_until(4, 8, 1'b0);
        close_test(1, "reset", err0);

        err0 = err_cnt;
        apply_reset(3'd7, 1'b0, 4'hf, '0, '0);
        quiet_ovr = 1'b1;
        drive_until(48, 5, 1'b0);            // small codes free each slice before its turn
        quiet_ovr = 1'b0;
        close_test(2, "slow sampling", err0);

        err0 = err_cnt;
        apply_reset(3'd7, 1'b0, 4'hf, TRIM_P, TRIM_N);
        drive_until(40, 8, 1'b1);
        assert (seen_max && seen_min)
            else report_fault("no output came from the end-of-range samples");
        close_test(3, "per-slice trims", err0);

        err0 = err_cnt;
        apply_reset(3'd7, 1'b0, 4'b1011, TRIM_P, TRIM_N);
        drive_until(40, 8, 1'b0);
        close_test(4, "disabled slice", err0);

        err0 = err_cnt;
        apply_reset(3'd0, 1'b1, 4'hf, TRIM_P, TRIM_N);
        drive_until(64, 8, 1'b0);
        assert (overrun)
            else report_fault("overrun never rose with the divider bypassed");
        close_test(5, "overrun", err0);

        err0 = err_cnt;
        apply_reset(3'd2, 1'b0, 4'hf, TRIM_P, TRIM_N);
        drive_until(32, 8, 1'b0);
        assert (frame_cnt == out_cnt / Nti)
            else report_mismatch($sformatf("%0d frames for %0d outputs", frame_cnt, out_cnt));
        close_test(6, "frame marker", err0);

        $display("summary: 6 tests, %0d cycles, %0d errors", cycle_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== analog_core.f ====
acore_const_pkg.sv
acore_type_pkg.sv
slice_intf.sv
input_divider.sv
snh.sv
stochastic_adc_slice.sv
adc_retimer.sv
analog_core.sv
tb_analog_core.sv

// ==== Makefile ====
TOP = tb_analog_core

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f analog_core.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
